// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [31:0] resetPc = 32'h0000_0000;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // Function codes under opSpecial
    localparam logic [5:0] fnJr = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOp;

    typedef enum logic [1:0] {wbNone, wbAlu, wbMemory} wbSource;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    // Low 26 bits double as the jump target
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] imm;
    } iFields;

    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

endpackage

`default_nettype wire

// File: verilog/fetchUnit.sv
`timescale 1ns/1ns
`default_nettype none

module fetchUnit import cpuPkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,
    input wire logic redirect,
    input wire logic [dataWidth-1:0] redirectPc,
    output instrWord fetchInstr,
    output logic [dataWidth-1:0] fetchPc,
    output logic fetchBubble,
    output logic [dataWidth-1:0] instAddr,
    output logic instReadEn,
    input wire logic [dataWidth-1:0] instRdata,
    input wire logic instValid
);

    logic running;
    logic [dataWidth-1:0] pc;
    logic bufValid;
    instrWord bufInstr;
    logic [dataWidth-1:0] bufPc;
    logic pendingRedirect;
    logic [dataWidth-1:0] pendingPc;
    logic fetchDone;

    assign instAddr = pc;
    assign instReadEn = running && !bufValid;
    assign fetchDone = instReadEn && instValid;

    // Buffered word first, else straight from the SRAM
    assign fetchInstr = bufValid ? bufInstr : instRdata;
    assign fetchPc = bufValid ? bufPc : pc;
    assign fetchBubble = !(bufValid || fetchDone);

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc <= resetPc;
            bufValid <= 1'b0;
            pendingRedirect <= 1'b0;
        end else begin
            running <= 1'b1;
            if (fetchDone) begin
                pendingRedirect <= 1'b0;
                if (redirect) begin
                    pc <= redirectPc;
                end else if (pendingRedirect) begin
                    pc <= pendingPc;
                end else begin
                    pc <= pc + 'd4;
                end
            end else if (redirect) begin
                // Delay slot still in flight, apply target once it lands
                if (instReadEn) begin
                    pendingRedirect <= 1'b1;
                    pendingPc <= redirectPc;
                end else begin
                    pc <= redirectPc;
                end
            end

            if (!stall) begin
                bufValid <= 1'b0;
            end else if (fetchDone) begin
                bufValid <= 1'b1;
                bufInstr <= instRdata;
                bufPc <= pc;
            end
        end
    end

    instAddrStable: assert property (@(posedge clk) disable iff (reset)
        instReadEn && !instValid |=> instReadEn && $stable(instAddr));

endmodule

`default_nettype wire

// File: verilog/decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder import cpuPkg::*; (
    input instrWord instr,
    output logic [regAddrWidth-1:0] rs,
    output logic [regAddrWidth-1:0] rt,
    output logic [regAddrWidth-1:0] dest,
    output logic [dataWidth-1:0] imm,
    output aluOp aluOpSel,
    output logic useImm,
    output logic isBranch,
    output logic branchOnNotEqual,
    output logic isJump,
    output logic isJumpReg,
    output logic memLoad,
    output logic memStore,
    output wbSource wbSel
);

    always_comb begin
        rs = instr.r.rs;
        rt = instr.r.rt;
        dest = '0;
        imm = {{16{instr.i.imm[15]}}, instr.i.imm};
        aluOpSel = aluAdd;
        useImm = 1'b0;
        isBranch = 1'b0;
        branchOnNotEqual = 1'b0;
        isJump = 1'b0;
        isJumpReg = 1'b0;
        memLoad = 1'b0;
        memStore = 1'b0;
        wbSel = wbNone;
        case (instr.r.op)
            opSpecial: begin
                dest = instr.r.rd;
                wbSel = wbAlu;
                case (instr.r.funct)
                    fnAddu: aluOpSel = aluAdd;
                    fnSubu: aluOpSel = aluSub;
                    fnAnd: aluOpSel = aluAnd;
                    fnOr: aluOpSel = aluOr;
                    fnSlt: aluOpSel = aluSlt;
                    fnJr: begin
                        isJumpReg = 1'b1;
                        dest = '0;
                        wbSel = wbNone;
                    end
                    default: begin
                        dest = '0;
                        wbSel = wbNone;
                    end
                endcase
            end
            opAddiu: begin
                dest = instr.i.rt;
                useImm = 1'b1;
                wbSel = wbAlu;
            end
            opOri, opLui: begin
                // Both take the immediate zero-extended
                imm = {16'h0000, instr.i.imm};
                dest = instr.i.rt;
                useImm = 1'b1;
                aluOpSel = (instr.i.op == opLui) ? aluLui : aluOr;
                wbSel = wbAlu;
            end
            opLw: begin
                dest = instr.i.rt;
                useImm = 1'b1;
                memLoad = 1'b1;
                wbSel = wbMemory;
            end
            opSw: begin
                useImm = 1'b1;
                memStore = 1'b1;
            end
            opBeq: isBranch = 1'b1;
            opBne: begin
                isBranch = 1'b1;
                branchOnNotEqual = 1'b1;
            end
            opJ: isJump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile import cpuPkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic [regAddrWidth-1:0] readAddr1,
    input wire logic [regAddrWidth-1:0] readAddr2,
    output logic [dataWidth-1:0] readData1,
    output logic [dataWidth-1:0] readData2,
    input wire logic [regAddrWidth-1:0] writeAddr,
    input wire logic [dataWidth-1:0] writeData
);

    // Register zero has no storage
    logic [dataWidth-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write is visible to the reader
    assign readData1 = (readAddr1 == '0) ? '0 :
                       (readAddr1 == writeAddr) ? writeData : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 :
                       (readAddr2 == writeAddr) ? writeData : regs[readAddr2];

endmodule

`default_nettype wire

// File: verilog/forwardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module forwardUnit import cpuPkg::*; (
    input wire logic [regAddrWidth-1:0] request,
    input wire logic [dataWidth-1:0] original,
    input wire logic [regAddrWidth-1:0] memDest,
    input wire logic [dataWidth-1:0] memValue,
    input wire logic memIsLoad,
    input wire logic [regAddrWidth-1:0] wbDest,
    input wire logic [dataWidth-1:0] wbValue,
    output logic [dataWidth-1:0] value,
    output logic hazard
);

    always_comb begin
        value = original;
        hazard = 1'b0;
        if (request != '0 && request == memDest) begin
            // Newest producer wins
            value = memValue;
            hazard = memIsLoad;
        end else if (request != '0 && request == wbDest) begin
            value = wbValue;
        end
    end

endmodule

`default_nettype wire

// File: verilog/memoryAccess.sv
`timescale 1ns/1ns
`default_nettype none

module memoryAccess import cpuPkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic load,
    input wire logic store,
    input wire logic [dataWidth-1:0] addr,
    input wire logic [dataWidth-1:0] storeData,
    output logic [dataWidth-1:0] loadData,
    output logic busy,
    output logic [dataWidth-1:0] dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output logic [dataWidth-1:0] dataWdata,
    input wire logic [dataWidth-1:0] dataRdata,
    input wire logic dataValid
);

    logic done;

    // Request drops once the access has completed
    assign dataRead = load && !done;
    assign dataWrite = store && !done;
    assign dataAddr = addr;
    assign dataWdata = storeData;
    assign busy = (load || store) && !done;

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= (dataRead || dataWrite) && dataValid;
        end
    end

    always_ff @(posedge clk) begin
        if (dataRead && dataValid) begin
            loadData <= dataRdata;
        end
    end

    requestHeld: assert property (@(posedge clk) disable iff (reset)
        (dataRead || dataWrite) && !dataValid
        |=> $stable({dataRead, dataWrite, dataAddr, dataWdata}));

endmodule

`default_nettype wire

// File: verilog/cpuCore.sv
`timescale 1ns/1ns
`default_nettype none

module cpuCore import cpuPkg::*; (
    input wire logic clk,
    input wire logic reset,
    output logic [dataWidth-1:0] instAddr,
    output logic instReadEn,
    input wire logic [dataWidth-1:0] instRdata,
    input wire logic instValid,
    output logic [dataWidth-1:0] dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output logic [dataWidth-1:0] dataWdata,
    input wire logic [dataWidth-1:0] dataRdata,
    input wire logic dataValid,
    output logic [dataWidth-1:0] debugWbPc,
    output logic [3:0] debugWbRfWen,
    output logic [regAddrWidth-1:0] debugWbRfWnum,
    output logic [dataWidth-1:0] debugWbRfWdata
);

    instrWord fetchInstr;
    logic [dataWidth-1:0] fetchPc;
    logic fetchBubble;
    logic stall, hazard, hazardA, hazardB, redirect, branchTaken;
    logic [dataWidth-1:0] redirectPc, delaySlotPc;

    instrWord dInstr;
    logic [dataWidth-1:0] dPc;
    logic dBubble;
    logic [regAddrWidth-1:0] rs, rt, dest;
    logic [dataWidth-1:0] imm, rfData1, rfData2, srcA, srcB, aluB, aluResult;
    aluOp aluOpSel;
    wbSource wbSel;
    logic useImm, isBranch, branchOnNotEqual, isJump, isJumpReg, memLoad, memStore;

    logic mBubble, mLoad, mStore, memBusy;
    wbSource mWbSel;
    logic [regAddrWidth-1:0] mDest, mFwdDest;
    logic [dataWidth-1:0] mPc, mAlu, mStoreData, mValue, loadData;

    logic wBubble, wWrite;
    wbSource wWbSel;
    logic [regAddrWidth-1:0] wDest, wWriteAddr;
    logic [dataWidth-1:0] wPc, wValue;

    fetchUnit u_fetch (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
        .redirectPc(redirectPc), .fetchInstr(fetchInstr), .fetchPc(fetchPc),
        .fetchBubble(fetchBubble), .instAddr(instAddr), .instReadEn(instReadEn),
        .instRdata(instRdata), .instValid(instValid)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dBubble <= 1'b1;
        end else if (!stall) begin
            dBubble <= fetchBubble;
            dInstr <= fetchInstr;
            dPc <= fetchPc;
        end
    end

    decoder u_decoder (
        .instr(dInstr), .rs(rs), .rt(rt), .dest(dest), .imm(imm), .aluOpSel(aluOpSel),
        .useImm(useImm), .isBranch(isBranch), .branchOnNotEqual(branchOnNotEqual),
        .isJump(isJump), .isJumpReg(isJumpReg), .memLoad(memLoad), .memStore(memStore),
        .wbSel(wbSel)
    );

    registerFile u_regs (
        .clk(clk), .reset(reset), .readAddr1(rs), .readAddr2(rt), .readData1(rfData1),
        .readData2(rfData2), .writeAddr(wWriteAddr), .writeData(wValue)
    );

    forwardUnit u_fwdA (
        .request(rs), .original(rfData1), .memDest(mFwdDest), .memValue(mValue),
        .memIsLoad(mLoad && memBusy), .wbDest(wWriteAddr), .wbValue(wValue),
        .value(srcA), .hazard(hazardA)
    );

    forwardUnit u_fwdB (
        .request(rt), .original(rfData2), .memDest(mFwdDest), .memValue(mValue),
        .memIsLoad(mLoad && memBusy), .wbDest(wWriteAddr), .wbValue(wValue),
        .value(srcB), .hazard(hazardB)
    );

    assign hazard = !dBubble && (hazardA || hazardB);
    assign stall = hazard || memBusy;

    // ALU sits in decode
    assign aluB = useImm ? imm : srcB;
    always_comb begin
        case (aluOpSel)
            aluSub: aluResult = srcA - aluB;
            aluAnd: aluResult = srcA & aluB;
            aluOr: aluResult = srcA | aluB;
            aluSlt: aluResult = {31'b0, $signed(srcA) < $signed(aluB)};
            aluLui: aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = srcA + aluB;
        endcase
    end

    assign delaySlotPc = dPc + 'd4;
    assign branchTaken = isBranch && ((srcA == srcB) != branchOnNotEqual);
    assign redirect = !dBubble && !stall && (branchTaken || isJump || isJumpReg);
    assign redirectPc = isJumpReg ? srcA :
                        isJump ? {delaySlotPc[31:28], dInstr.i.rs, dInstr.i.rt,
                                  dInstr.i.imm, 2'b00} :
                        delaySlotPc + (imm << 2);

    // A load hazard implies a busy memory stage, so no hazard term here
    always_ff @(posedge clk) begin
        if (reset) begin
            mBubble <= 1'b1;
            mLoad <= 1'b0;
            mStore <= 1'b0;
            mWbSel <= wbNone;
        end else if (!memBusy) begin
            mBubble <= dBubble;
            mLoad <= !dBubble && memLoad;
            mStore <= !dBubble && memStore;
            mWbSel <= dBubble ? wbNone : wbSel;
        end
    end

    always_ff @(posedge clk) begin
        if (!memBusy) begin
            mDest <= dest;
            mPc <= dPc;
            mAlu <= aluResult;
            mStoreData <= srcB;
        end
    end

    memoryAccess u_mem (
        .clk(clk), .reset(reset), .load(mLoad), .store(mStore), .addr(mAlu),
        .storeData(mStoreData), .loadData(loadData), .busy(memBusy), .dataAddr(dataAddr),
        .dataRead(dataRead), .dataWrite(dataWrite), .dataWdata(dataWdata),
        .dataRdata(dataRdata), .dataValid(dataValid)
    );

    assign mFwdDest = (mWbSel != wbNone) ? mDest : '0;
    assign mValue = (mWbSel == wbMemory) ? loadData : mAlu;

    // A waiting memory stage sends a bubble on
    always_ff @(posedge clk) begin
        if (reset) begin
            wBubble <= 1'b1;
            wWbSel <= wbNone;
        end else begin
            wBubble <= mBubble || memBusy;
            wWbSel <= memBusy ? wbNone : mWbSel;
        end
    end

    always_ff @(posedge clk) begin
        wDest <= mDest;
        wPc <= mPc;
        wValue <= mValue;
    end

    assign wWrite = !wBubble && wWbSel != wbNone && wDest != '0;
    assign wWriteAddr = wWrite ? wDest : '0;

    assign debugWbPc = wPc;
    assign debugWbRfWen = wWrite ? 4'b1111 : 4'b0000;
    assign debugWbRfWnum = wDest;
    assign debugWbRfWdata = wValue;

    readWriteExclusive: assert property (@(posedge clk) disable iff (reset)
        !(dataRead && dataWrite));

endmodule

`default_nettype wire

// File: sim/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam int writebackTimeout = 100;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [31:0] instAddr;
    logic instReadEn;
    logic [31:0] instRdata = 32'h0000_0000;
    logic instValid = 1'b0;
    logic [31:0] dataAddr;
    logic dataRead;
    logic dataWrite;
    logic [31:0] dataWdata;
    logic [31:0] dataRdata = 32'h0000_0000;
    logic dataValid = 1'b0;
    logic [31:0] debugWbPc;
    logic [3:0] debugWbRfWen;
    logic [4:0] debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] rngState = 32'd99319;
    logic instPending = 1'b0;
    logic [1:0] instWaitLeft = 2'd0;
    logic dataPending = 1'b0;
    logic [1:0] dataWaitLeft = 2'd0;

    // Expected writebacks in program order
    logic [31:0] expPc [0:31];
    logic [4:0] expReg [0:31];
    logic [31:0] expData [0:31];
    logic [4:0] expCount = 5'd0;
    logic [4:0] expIndex = 5'd0;
    logic timedOut;

    cpuCore i_dut (
        .clk(clk), .reset(reset),
        .instAddr(instAddr), .instReadEn(instReadEn), .instRdata(instRdata),
        .instValid(instValid),
        .dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
        .dataWdata(dataWdata), .dataRdata(dataRdata), .dataValid(dataValid),
        .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJump(input logic [25:0] target);
        return {opJ, target};
    endfunction

    task automatic putInstr(input logic [31:0] pc, input logic [31:0] word);
        imem[pc[9:2]] = word;
    endtask

    task automatic expectWb(input logic [31:0] pc, input logic [4:0] regNum,
                            input logic [31:0] data);
        expPc[expCount] = pc;
        expReg[expCount] = regNum;
        expData[expCount] = data;
        expCount = expCount + 5'd1;
    endtask

    task automatic loadProgram();
        // Harmless addiu to r0 everywhere else
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = encodeI(opAddiu, 5'd0, 5'd0, i[15:0]);
        end
        putInstr(32'h00, encodeI(opLui, 5'd0, 5'd1, 16'h1234));
        putInstr(32'h04, encodeI(opOri, 5'd1, 5'd1, 16'h5678));
        putInstr(32'h08, encodeI(opAddiu, 5'd0, 5'd2, 16'hfffd));
        putInstr(32'h0c, encodeR(fnAddu, 5'd1, 5'd2, 5'd3));
        putInstr(32'h10, encodeR(fnSubu, 5'd3, 5'd1, 5'd4));
        putInstr(32'h14, encodeR(fnSlt, 5'd4, 5'd0, 5'd5));
        putInstr(32'h18, encodeR(fnAnd, 5'd1, 5'd3, 5'd6));
        putInstr(32'h1c, encodeR(fnOr, 5'd2, 5'd5, 5'd7));
        putInstr(32'h20, encodeI(opAddiu, 5'd0, 5'd0, 16'h0005));
        putInstr(32'h24, encodeR(fnAddu, 5'd0, 5'd5, 5'd8));
        putInstr(32'h28, encodeI(opAddiu, 5'd0, 5'd9, 16'h0100));
        putInstr(32'h2c, encodeI(opSw, 5'd9, 5'd1, 16'h0004));
        putInstr(32'h30, encodeI(opLw, 5'd9, 5'd10, 16'h0004));
        putInstr(32'h34, encodeR(fnAddu, 5'd10, 5'd5, 5'd11));
        // Taken beq, target 0x48
        putInstr(32'h38, encodeI(opBeq, 5'd10, 5'd1, 16'd3));
        putInstr(32'h3c, encodeI(opAddiu, 5'd0, 5'd12, 16'h0011));
        putInstr(32'h40, encodeI(opAddiu, 5'd0, 5'd13, 16'h0bad));
        putInstr(32'h44, encodeI(opAddiu, 5'd0, 5'd13, 16'h0bad));
        putInstr(32'h48, encodeI(opBne, 5'd10, 5'd1, 16'd2));
        putInstr(32'h4c, encodeI(opAddiu, 5'd0, 5'd14, 16'h0022));
        putInstr(32'h50, encodeJump(26'h18));
        putInstr(32'h54, encodeI(opAddiu, 5'd0, 5'd15, 16'h0033));
        putInstr(32'h58, encodeI(opAddiu, 5'd0, 5'd13, 16'h0bad));
        putInstr(32'h5c, encodeI(opAddiu, 5'd0, 5'd13, 16'h0bad));
        putInstr(32'h60, encodeI(opAddiu, 5'd0, 5'd16, 16'h0074));
        putInstr(32'h64, encodeR(fnJr, 5'd16, 5'd0, 5'd0));
        putInstr(32'h68, encodeI(opAddiu, 5'd0, 5'd17, 16'h0044));
        putInstr(32'h6c, encodeI(opAddiu, 5'd0, 5'd13, 16'h0bad));
        putInstr(32'h70, encodeI(opAddiu, 5'd0, 5'd13, 16'h0bad));
        putInstr(32'h74, encodeI(opLw, 5'd9, 5'd18, 16'h0004));
        // Final self-loop with a nop in its delay slot
        putInstr(32'h78, encodeJump(26'h1e));
        putInstr(32'h7c, 32'h0000_0000);
    endtask

    task automatic loadExpected();
        expectWb(32'h00, 5'd1, 32'h1234_0000);
        expectWb(32'h04, 5'd1, 32'h1234_5678);
        expectWb(32'h08, 5'd2, 32'hffff_fffd);
        expectWb(32'h0c, 5'd3, 32'h1234_5675);
        expectWb(32'h10, 5'd4, 32'hffff_fffd);
        expectWb(32'h14, 5'd5, 32'h0000_0001);
        expectWb(32'h18, 5'd6, 32'h1234_5670);
        expectWb(32'h1c, 5'd7, 32'hffff_fffd);
        expectWb(32'h24, 5'd8, 32'h0000_0001);
        expectWb(32'h28, 5'd9, 32'h0000_0100);
        expectWb(32'h30, 5'd10, 32'h1234_5678);
        expectWb(32'h34, 5'd11, 32'h1234_5679);
        expectWb(32'h3c, 5'd12, 32'h0000_0011);
        expectWb(32'h4c, 5'd14, 32'h0000_0022);
        expectWb(32'h54, 5'd15, 32'h0000_0033);
        expectWb(32'h60, 5'd16, 32'h0000_0074);
        expectWb(32'h68, 5'd17, 32'h0000_0044);
        expectWb(32'h74, 5'd18, 32'h1234_5678);
    endtask

    // Both SRAM models, answering after 0 to 3 cycles
    always @(negedge clk) begin
        if (reset) begin
            instValid <= 1'b0;
            dataValid <= 1'b0;
            instPending = 1'b0;
            dataPending = 1'b0;
            for (int i = 0; i < 256; i++) begin
                dmem[i[7:0]] <= 32'hda7a_0000 | i;
            end
        end else begin
            if (instValid) begin
                instPending = 1'b0;
            end
            if (instReadEn && !instPending) begin
                rngState = lcgNext(rngState);
                instPending = 1'b1;
                instWaitLeft = rngState[17:16];
            end
            if (instPending && instWaitLeft == 2'd0) begin
                instValid <= 1'b1;
                instRdata <= imem[instAddr[9:2]];
            end else begin
                instValid <= 1'b0;
                if (instPending) begin
                    instWaitLeft = instWaitLeft - 2'd1;
                end
            end

            if (dataValid) begin
                dataPending = 1'b0;
            end
            if ((dataRead || dataWrite) && !dataPending) begin
                rngState = lcgNext(rngState);
                dataPending = 1'b1;
                dataWaitLeft = rngState[17:16];
            end
            if (dataPending && dataWaitLeft == 2'd0) begin
                dataValid <= 1'b1;
                dataRdata <= dmem[dataAddr[9:2]];
                if (dataWrite) begin
                    dmem[dataAddr[9:2]] <= dataWdata;
                end
            end else begin
                dataValid <= 1'b0;
                if (dataPending) begin
                    dataWaitLeft = dataWaitLeft - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            expIndex <= 5'd0;
        end else if (debugWbRfWen != 4'b0000) begin
            expIndex <= expIndex + 5'd1;
        end
    end

    wbInOrder: assert property (@(posedge clk) disable iff (reset)
        debugWbRfWen != 4'b0000 |-> expIndex < expCount && debugWbPc == expPc[expIndex]
            && debugWbRfWnum == expReg[expIndex] && debugWbRfWdata == expData[expIndex])
        else begin
            $display("mismatch at %0t: writeback %0d, expected pc %h reg %0d data %h",
                     $time, $sampled(expIndex), expPc[$sampled(expIndex)],
                     expReg[$sampled(expIndex)], expData[$sampled(expIndex)]);
            $display("Errors found");
            $fatal(1);
        end

    zeroNeverWritten: assert property (@(posedge clk) disable iff (reset)
        debugWbRfWen != 4'b0000 |-> debugWbRfWnum != 5'd0)
        else begin
            $display("write enable raised for register zero at %0t", $time);
            $display("Errors found");
            $fatal(1);
        end

    wenAllOrNone: assert property (@(posedge clk) disable iff (reset)
        debugWbRfWen == 4'b0000 || debugWbRfWen == 4'b1111)
        else begin
            $display("write enable is neither all low nor all high at %0t", $time);
            $display("Errors found");
            $fatal(1);
        end

    // Gap counter restarts at every writeback
    task automatic waitForWritebacks(output logic failed);
        int gap;
        logic [4:0] lastIndex;
        gap = 0;
        lastIndex = expIndex;
        failed = 1'b0;
        while (expIndex < expCount && !failed) begin
            @(negedge clk);
            if (expIndex != lastIndex) begin
                gap = 0;
                lastIndex = expIndex;
            end else begin
                gap = gap + 1;
            end
            if (gap > writebackTimeout) begin
                $display("timeout: writeback %0d never appeared at the debug port", expIndex);
                failed = 1'b1;
            end
        end
    endtask

    initial begin
        loadProgram();
        loadExpected();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
        waitForWritebacks(timedOut);
        if (timedOut) begin
            $display("Errors found");
            $fatal(1);
        end else begin
            // Spin in the self-loop, any further writeback fails wbInOrder
            repeat (40) @(negedge clk);
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/decoder.sv
verilog/registerFile.sv
verilog/forwardUnit.sv
verilog/memoryAccess.sv
verilog/cpuCore.sv
sim/cpuTb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module cpuTb \
		-Mdir obj_dir -o cpuTb
	./obj_dir/cpuTb

lint:
	verilator --lint-only --timing --assert -Wall -f project.f --top-module cpuTb

clean:
	rm -rf obj_dir
